//--- compile.f
board_regs_pkg.sv
reg_access_if.sv
axi_write_ctrl.sv
axi_read_ctrl.sv
board_reg_file.sv
board_regs_top.sv
tb_clock_gen.sv
tb_checker.sv
tb_board_regs.sv

//--- Bender.yml
package:
  name: board_regs

sources:
  - board_regs_pkg.sv
  - reg_access_if.sv
  - axi_write_ctrl.sv
  - axi_read_ctrl.sv
  - board_reg_file.sv
  - board_regs_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_checker.sv
      - tb_board_regs.sv

//--- tb_board_regs.sv
`timescale 1ns/1ns
`default_nettype none

module tb_board_regs;
	import board_regs_pkg::*;

	localparam int          N_OPS = 18;
	localparam logic [31:0] SEED  = 32'h15d8fb73;

	typedef struct packed {
		bit        is_wr;
		axi_addr_t addr;
		axi_len_t  len;
		axi_data_t data;
		bit        rnd;
		axi_strb_t strb;
		bit        stall;
	} op_t;

	logic axi_clk;
	logic axi_rst;
	axi_id_t awid;
	axi_addr_t awaddr;
	logic awvalid;
	wire awready;
	axi_data_t wdata;
	axi_strb_t wstrb;
	logic wlast;
	logic wvalid;
	wire wready;
	wire axi_id_t bid;
	wire axi_resp_t bresp;
	wire bvalid;
	logic bready;
	axi_id_t arid;
	axi_addr_t araddr;
	axi_len_t arlen;
	logic arvalid;
	wire arready;
	wire axi_id_t rid;
	wire axi_data_t rdata;
	wire axi_resp_t rresp;
	wire rlast;
	wire rvalid;
	logic rready;
	axi_data_t reg_fpga_rev;
	logic [SW1_W-1:0] reg_sw1;
	logic reg_led_5;
	wire [JP3_W-1:0] reg_jp3;
	wire [LED_W-1:0] reg_led;
	wire [JP5_W-1:0] reg_jp5;
	wire [JP4_W-1:0] reg_jp4_rxn;
	wire [JP4_W-1:0] reg_jp4_rxp;
	wire [JP4_W-1:0] reg_jp4_txn;
	wire [JP4_W-1:0] reg_jp4_txp;
	int err_cnt;
	int chk_cnt;

	op_t ops [N_OPS];

	tb_clock_gen u_clk (
		.axi_clk (axi_clk),
		.axi_rst (axi_rst)
	);

	board_regs_top u_dut (.*);

	tb_checker u_chk (.*);

	function automatic op_t make_op(input bit is_wr, input logic [7:0] addr, input int len,
		input axi_data_t data, input bit rnd, input axi_strb_t strb, input bit stall);
		op_t op;
		op.is_wr = is_wr;
		op.addr  = axi_addr_t'(addr);
		op.len   = axi_len_t'(len);
		op.data  = data;
		op.rnd   = rnd;
		op.strb  = strb;
		op.stall = stall;
		return op;
	endfunction

	// ==========================================================
	// Stimulus table of kind, byte address, len-1, data, random flag, strobes and stalls
	// ==========================================================
	task automatic load_table();
		// Reset values of all four words
		ops[0]  = make_op(0, 8'h00, 3, 32'h0, 0, 4'h0, 0);
		// Full-strobe single writes and read-back
		ops[1]  = make_op(1, 8'h04, 0, 32'hFFFF_FA0A, 0, 4'hF, 0);
		ops[2]  = make_op(1, 8'h08, 0, 32'hFFF1_2345, 0, 4'hF, 0);
		ops[3]  = make_op(1, 8'h0C, 0, 32'hEA15_F30C, 0, 4'hF, 0);
		ops[4]  = make_op(0, 8'h04, 2, 32'h0, 0, 4'h0, 0);
		// Partial strobes
		ops[5]  = make_op(1, 8'h0C, 0, 32'h3F3F_3F3F, 0, 4'b0101, 0);
		ops[6]  = make_op(1, 8'h08, 0, 32'hFFFF_AAFF, 0, 4'b0010, 0);
		ops[7]  = make_op(1, 8'h04, 0, 32'h0000_0000, 0, 4'b0001, 0);
		ops[8]  = make_op(0, 8'h04, 2, 32'h0, 0, 4'h0, 0);
		// Four-beat burst from 04h, then six-beat read from 00h
		ops[9]  = make_op(1, 8'h04, 3, 32'h1234_5678, 0, 4'hF, 0);
		ops[10] = make_op(0, 8'h00, 5, 32'h0, 0, 4'h0, 0);
		// Random data with back-pressure
		ops[11] = make_op(1, 8'h00, 0, 32'h0, 1, 4'hF, 1);
		ops[12] = make_op(1, 8'h04, 2, 32'h0, 1, 4'hF, 1);
		ops[13] = make_op(0, 8'h00, 15, 32'h0, 0, 4'h0, 1);
		ops[14] = make_op(1, 8'h08, 1, 32'h0, 1, 4'hF, 1);
		ops[15] = make_op(0, 8'h08, 1, 32'h0, 0, 4'h0, 1);
		// Index wraps from 7Ch back to 00h
		ops[16] = make_op(0, 8'h7C, 2, 32'h0, 0, 4'h0, 1);
		// Single-beat read is last on its first beat
		ops[17] = make_op(0, 8'h0C, 0, 32'h0, 0, 4'h0, 1);
	endtask

	function automatic logic pick_ready(input bit stall);
		if (!stall)
			return 1'b1;
		return ($urandom % 4) != 0;
	endfunction

	task automatic do_write(input op_t op, input axi_id_t id);
		int k;
		@(negedge axi_clk);
		awid    = id;
		awaddr  = op.addr;
		awvalid = 1'b1;
		while (!awready)
			@(negedge axi_clk);
		@(negedge axi_clk);
		awvalid = 1'b0;
		for (k = 0; k <= int'(op.len); k++)
		begin
			wdata  = op.rnd ? axi_data_t'($urandom) : op.data + axi_data_t'(k);
			wstrb  = op.strb;
			wlast  = (k == int'(op.len));
			wvalid = 1'b1;
			while (!wready)
				@(negedge axi_clk);
			@(negedge axi_clk);
		end
		wvalid = 1'b0;
		wlast  = 1'b0;
		bready = pick_ready(op.stall);
		while (!(bvalid && bready))
		begin
			@(negedge axi_clk);
			bready = pick_ready(op.stall);
		end
		@(negedge axi_clk);
		bready = 1'b0;
	endtask

	task automatic do_read(input op_t op, input axi_id_t id);
		bit done;
		@(negedge axi_clk);
		arid    = id;
		araddr  = op.addr;
		arlen   = op.len;
		arvalid = 1'b1;
		while (!arready)
			@(negedge axi_clk);
		@(negedge axi_clk);
		arvalid = 1'b0;
		done = 1'b0;
		while (!done)
		begin
			rready = pick_ready(op.stall);
			if (rvalid && rready && rlast)
				done = 1'b1;
			@(negedge axi_clk);
		end
		rready = 1'b0;
	endtask

	// ==========================================================
	// Main sequence
	// ==========================================================
	initial
	begin
		void'($urandom(SEED));
		awid = '0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wlast = 1'b0;
		wvalid = 1'b0;
		bready = 1'b0;
		arid = '0;
		araddr = '0;
		arlen = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		reg_fpga_rev = 32'h5EC0_0A17;
		reg_sw1 = 4'hB;
		reg_led_5 = 1'b1;
		load_table();
		wait (axi_rst === 1'b1);
		wait (axi_rst === 1'b0);
		repeat (2) @(negedge axi_clk);
		for (int i = 0; i < N_OPS; i++)
		begin
			if (ops[i].is_wr)
				do_write(ops[i], axi_id_t'(12'h0A0 + 3 * i));
			else
				do_read(ops[i], axi_id_t'(12'h0A0 + 3 * i));
		end
		repeat (4) @(negedge axi_clk);
		$display("Summary: %0d checks, %0d errors", chk_cnt, err_cnt);
		if (err_cnt == 0 && chk_cnt > 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

	// Watchdog allows 200 cycles per table entry
	initial
	begin
		repeat (N_OPS * 200) @(posedge axi_clk);
		$display("Timeout: the AXI transfers did not finish within %0d clock cycles",
			N_OPS * 200);
		$display("Summary: %0d checks, %0d errors", chk_cnt, err_cnt);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb_checker.sv
`timescale 1ns/1ns
`default_nettype none

module tb_checker (
	input  wire                                axi_clk,
	input  wire                                axi_rst,
	input  wire board_regs_pkg::axi_id_t       awid,
	input  wire board_regs_pkg::axi_addr_t     awaddr,
	input  wire                                awvalid,
	input  wire                                awready,
	input  wire board_regs_pkg::axi_data_t     wdata,
	input  wire board_regs_pkg::axi_strb_t     wstrb,
	input  wire                                wlast,
	input  wire                                wvalid,
	input  wire                                wready,
	input  wire board_regs_pkg::axi_id_t       bid,
	input  wire board_regs_pkg::axi_resp_t     bresp,
	input  wire                                bvalid,
	input  wire                                bready,
	input  wire board_regs_pkg::axi_id_t       arid,
	input  wire board_regs_pkg::axi_addr_t     araddr,
	input  wire board_regs_pkg::axi_len_t      arlen,
	input  wire                                arvalid,
	input  wire                                arready,
	input  wire board_regs_pkg::axi_id_t       rid,
	input  wire board_regs_pkg::axi_data_t     rdata,
	input  wire board_regs_pkg::axi_resp_t     rresp,
	input  wire                                rlast,
	input  wire                                rvalid,
	input  wire                                rready,
	input  wire board_regs_pkg::axi_data_t     reg_fpga_rev,
	input  wire [board_regs_pkg::SW1_W-1:0]    reg_sw1,
	input  wire                                reg_led_5,
	input  wire [board_regs_pkg::JP3_W-1:0]    reg_jp3,
	input  wire [board_regs_pkg::LED_W-1:0]    reg_led,
	input  wire [board_regs_pkg::JP5_W-1:0]    reg_jp5,
	input  wire [board_regs_pkg::JP4_W-1:0]    reg_jp4_rxn,
	input  wire [board_regs_pkg::JP4_W-1:0]    reg_jp4_rxp,
	input  wire [board_regs_pkg::JP4_W-1:0]    reg_jp4_txn,
	input  wire [board_regs_pkg::JP4_W-1:0]    reg_jp4_txp,
	output int                                 err_cnt,
	output int                                 chk_cnt
);
	import board_regs_pkg::*;

	// Shadow copy of the writable fields
	logic [JP3_W-1:0] m_jp3;
	logic [LED_W-1:0] m_led;
	logic [JP5_W-1:0] m_jp5;
	logic [JP4_W-1:0] m_rxn;
	logic [JP4_W-1:0] m_rxp;
	logic [JP4_W-1:0] m_txn;
	logic [JP4_W-1:0] m_txp;

	reg_idx_t w_idx;
	reg_idx_t r_idx;
	axi_id_t  b_id_exp;
	axi_id_t  r_id_exp;
	axi_len_t r_len;
	int       r_beat;
	bit       r_open;
	bit       b_due;
	bit       idle_checked;

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		chk_cnt++;
		if (got !== exp)
		begin
			err_cnt++;
			$display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	function automatic axi_data_t expected_word(input reg_idx_t idx);
		axi_data_t w;
		w = '0;
		case (idx)
			REG_FPGA_INFO: w = reg_fpga_rev;
			REG_HW_CTRL:
			begin
				w[19:16] = reg_sw1;
				w[11:8]  = m_jp3;
				w[3:1]   = m_led;
				w[0]     = reg_led_5;
			end
			REG_EXT_CTRL1: w[19:0] = m_jp5;
			REG_EXT_CTRL2:
			begin
				w[29:24] = m_rxn;
				w[21:16] = m_rxp;
				w[13:8]  = m_txn;
				w[5:0]   = m_txp;
			end
			default: w = '0;
		endcase
		return w;
	endfunction

	// Field changes only where its byte lane is enabled
	task automatic apply_write(input reg_idx_t idx, input axi_data_t d, input axi_strb_t s);
		case (idx)
			REG_HW_CTRL:
			begin
				if (s[1])
					m_jp3 = d[11:8];
				if (s[0])
					m_led = d[3:1];
			end
			REG_EXT_CTRL1:
			begin
				if (s[2])
					m_jp5[19:16] = d[19:16];
				if (s[1])
					m_jp5[15:8] = d[15:8];
				if (s[0])
					m_jp5[7:0] = d[7:0];
			end
			REG_EXT_CTRL2:
			begin
				if (s[3])
					m_rxn = d[29:24];
				if (s[2])
					m_rxp = d[21:16];
				if (s[1])
					m_txn = d[13:8];
				if (s[0])
					m_txp = d[5:0];
			end
			default: ;
		endcase
	endtask

	task automatic check_pins();
		check_value("jp3 pins", 32'(reg_jp3), 32'(m_jp3));
		check_value("led pins", 32'(reg_led), 32'(m_led));
		check_value("jp5 pins", 32'(reg_jp5), 32'(m_jp5));
		check_value("jp4_rxn pins", 32'(reg_jp4_rxn), 32'(m_rxn));
		check_value("jp4_rxp pins", 32'(reg_jp4_rxp), 32'(m_rxp));
		check_value("jp4_txn pins", 32'(reg_jp4_txn), 32'(m_txn));
		check_value("jp4_txp pins", 32'(reg_jp4_txp), 32'(m_txp));
	endtask

	// ==========================================================
	// Handshake monitor
	// ==========================================================
	always @(posedge axi_clk)
	begin
		if (axi_rst)
		begin
			m_jp3 = '0;
			m_led = '1;
			m_jp5 = '1;
			m_rxn = '1;
			m_rxp = '1;
			m_txn = '1;
			m_txp = '1;
			r_open = 1'b0;
			b_due = 1'b0;
			idle_checked = 1'b0;
			err_cnt = 0;
			chk_cnt = 0;
		end
		else
		begin
			if (!idle_checked)
			begin
				check_value("ready/valid after reset",
					{26'd0, awready, arready, wready, bvalid, rvalid, rlast},
					32'b110000);
				idle_checked = 1'b1;
			end
			// Response follows the last write beat by one cycle
			if (b_due)
			begin
				check_value("bvalid after last W beat", 32'(bvalid), 32'd1);
			end
			b_due = wvalid && wready && wlast;
			if (awvalid && awready)
			begin
				w_idx = awaddr[6:2];
				b_id_exp = awid;
			end
			if (wvalid && wready)
			begin
				apply_write(w_idx, wdata, wstrb);
				w_idx = w_idx + 5'd1;
			end
			if (bvalid && bready)
			begin
				check_value("bid", 32'(bid), 32'(b_id_exp));
				check_value("bresp", 32'(bresp), 32'(2'b00));
			end
			if (arvalid && arready)
			begin
				if (r_open)
				begin
					err_cnt++;
					$display("ERROR at %0t ns: new read accepted before the last one ended",
						$time);
				end
				r_idx = araddr[6:2];
				r_len = arlen;
				r_id_exp = arid;
				r_beat = 0;
				r_open = 1'b1;
				check_pins();
			end
			if (rvalid && rready)
			begin
				if (!r_open)
				begin
					err_cnt++;
					$display("ERROR at %0t ns: read data beat came with no read open", $time);
				end
				else
				begin
					check_value($sformatf("rdata idx %0d", r_idx), rdata, expected_word(r_idx));
					check_value("rid", 32'(rid), 32'(r_id_exp));
					check_value("rresp", 32'(rresp), 32'(2'b00));
					check_value($sformatf("rlast beat %0d", r_beat), 32'(rlast),
						32'(r_beat == int'(r_len)));
					r_beat++;
					r_idx = r_idx + 5'd1;
					if (rlast)
						r_open = 1'b0;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
	output logic axi_clk,
	output logic axi_rst
);
	localparam int HALF_PERIOD_NS = 5;
	localparam int RST_CYCLES     = 16;

	initial
	begin
		axi_clk = 1'b0;
		forever
			#(HALF_PERIOD_NS) axi_clk = ~axi_clk;
	end

	// Reset released on a falling edge, like every other DUT input
	initial
	begin
		axi_rst = 1'b1;
		repeat (RST_CYCLES) @(posedge axi_clk);
		@(negedge axi_clk);
		axi_rst = 1'b0;
	end

endmodule

`default_nettype wire

//--- board_regs_top.sv
`timescale 1ns/1ns
`default_nettype none

module board_regs_top (
	input  wire                                axi_clk,
	input  wire                                axi_rst,
	// AXI write address, data and response
	input  wire board_regs_pkg::axi_id_t          awid,
	input  wire board_regs_pkg::axi_addr_t        awaddr,
	input  wire                                awvalid,
	output wire                                awready,
	input  wire board_regs_pkg::axi_data_t        wdata,
	input  wire board_regs_pkg::axi_strb_t        wstrb,
	input  wire                                wlast,
	input  wire                                wvalid,
	output wire                                wready,
	output wire board_regs_pkg::axi_id_t          bid,
	output wire board_regs_pkg::axi_resp_t        bresp,
	output wire                                bvalid,
	input  wire                                bready,
	// AXI read address and data
	input  wire board_regs_pkg::axi_id_t          arid,
	input  wire board_regs_pkg::axi_addr_t        araddr,
	input  wire board_regs_pkg::axi_len_t         arlen,
	input  wire                                arvalid,
	output wire                                arready,
	output wire board_regs_pkg::axi_id_t          rid,
	output wire board_regs_pkg::axi_data_t        rdata,
	output wire board_regs_pkg::axi_resp_t        rresp,
	output wire                                rlast,
	output wire                                rvalid,
	input  wire                                rready,
	// Board pins
	input  wire board_regs_pkg::axi_data_t        reg_fpga_rev,
	input  wire [board_regs_pkg::SW1_W-1:0]    reg_sw1,
	input  wire                                reg_led_5,
	output wire [board_regs_pkg::JP3_W-1:0]    reg_jp3,
	output wire [board_regs_pkg::LED_W-1:0]    reg_led,
	output wire [board_regs_pkg::JP5_W-1:0]    reg_jp5,
	output wire [board_regs_pkg::JP4_W-1:0]    reg_jp4_rxn,
	output wire [board_regs_pkg::JP4_W-1:0]    reg_jp4_rxp,
	output wire [board_regs_pkg::JP4_W-1:0]    reg_jp4_txn,
	output wire [board_regs_pkg::JP4_W-1:0]    reg_jp4_txp
);

	reg_access_if acc_if ();

	// ==========================================================
	// Bus side, write and read paths run independently
	// ==========================================================
	axi_write_ctrl u_wr (
		.axi_clk (axi_clk),
		.axi_rst (axi_rst),
		.awid    (awid),
		.awaddr  (awaddr),
		.awvalid (awvalid),
		.awready (awready),
		.wdata   (wdata),
		.wstrb   (wstrb),
		.wlast   (wlast),
		.wvalid  (wvalid),
		.wready  (wready),
		.bid     (bid),
		.bresp   (bresp),
		.bvalid  (bvalid),
		.bready  (bready),
		.acc     (acc_if.wr_side)
	);

	axi_read_ctrl u_rd (
		.axi_clk (axi_clk),
		.axi_rst (axi_rst),
		.arid    (arid),
		.araddr  (araddr),
		.arlen   (arlen),
		.arvalid (arvalid),
		.arready (arready),
		.rid     (rid),
		.rdata   (rdata),
		.rresp   (rresp),
		.rlast   (rlast),
		.rvalid  (rvalid),
		.rready  (rready),
		.acc     (acc_if.rd_side)
	);

	// Register storage and board pins
	board_reg_file u_regs (
		.axi_clk  (axi_clk),
		.axi_rst  (axi_rst),
		.acc      (acc_if.regs),
		.fpga_rev (reg_fpga_rev),
		.sw1      (reg_sw1),
		.led_5    (reg_led_5),
		.jp3      (reg_jp3),
		.led      (reg_led),
		.jp5      (reg_jp5),
		.jp4_rxn  (reg_jp4_rxn),
		.jp4_rxp  (reg_jp4_rxp),
		.jp4_txn  (reg_jp4_txn),
		.jp4_txp  (reg_jp4_txp)
	);

endmodule

`default_nettype wire

//--- board_reg_file.sv
`timescale 1ns/1ns
`default_nettype none

module board_reg_file (
	input  wire                               axi_clk,
	input  wire                               axi_rst,
	reg_access_if.regs                        acc,
	input  wire board_regs_pkg::axi_data_t       fpga_rev,
	input  wire [board_regs_pkg::SW1_W-1:0]   sw1,
	input  wire                               led_5,
	output logic [board_regs_pkg::JP3_W-1:0]  jp3,
	output logic [board_regs_pkg::LED_W-1:0]  led,
	output logic [board_regs_pkg::JP5_W-1:0]  jp5,
	output logic [board_regs_pkg::JP4_W-1:0]  jp4_rxn,
	output logic [board_regs_pkg::JP4_W-1:0]  jp4_rxp,
	output logic [board_regs_pkg::JP4_W-1:0]  jp4_txn,
	output logic [board_regs_pkg::JP4_W-1:0]  jp4_txp
);
	import board_regs_pkg::*;

	axi_data_t word_hw;
	axi_data_t word_ext1;
	axi_data_t word_ext2;

	// ==========================================================
	// Write decode, one byte lane per field group
	// ==========================================================
	always_ff @(posedge axi_clk)
	begin
		if (axi_rst)
		begin
			jp3     <= JP3_RST;
			led     <= LED_RST;
			jp5     <= JP5_RST;
			jp4_rxn <= JP4_RST;
			jp4_rxp <= JP4_RST;
			jp4_txn <= JP4_RST;
			jp4_txp <= JP4_RST;
		end
		else if (acc.wr_en)
		begin
			case (acc.wr_idx)
				REG_HW_CTRL:
				begin
					if (acc.wr_strb[1])
						jp3 <= acc.wr_data[8 +: JP3_W];
					if (acc.wr_strb[0])
						led <= acc.wr_data[1 +: LED_W];
				end
				REG_EXT_CTRL1:
				begin
					if (acc.wr_strb[2])
						jp5[JP5_W-1:16] <= acc.wr_data[JP5_W-1:16];
					if (acc.wr_strb[1])
						jp5[15:8] <= acc.wr_data[15:8];
					if (acc.wr_strb[0])
						jp5[7:0] <= acc.wr_data[7:0];
				end
				REG_EXT_CTRL2:
				begin
					if (acc.wr_strb[3])
						jp4_rxn <= acc.wr_data[24 +: JP4_W];
					if (acc.wr_strb[2])
						jp4_rxp <= acc.wr_data[16 +: JP4_W];
					if (acc.wr_strb[1])
						jp4_txn <= acc.wr_data[8 +: JP4_W];
					if (acc.wr_strb[0])
						jp4_txp <= acc.wr_data[0 +: JP4_W];
				end
				// Revision word and unmapped space ignore writes
				default: ;
			endcase
		end
	end

	// ==========================================================
	// Read words, reserved bits zero
	// ==========================================================
	always_comb
	begin
		word_hw                = '0;
		word_hw[16 +: SW1_W]   = sw1;
		word_hw[8 +: JP3_W]    = jp3;
		word_hw[1 +: LED_W]    = led;
		word_hw[0]             = led_5;

		word_ext1              = '0;
		word_ext1[JP5_W-1:0]   = jp5;

		word_ext2              = '0;
		word_ext2[24 +: JP4_W] = jp4_rxn;
		word_ext2[16 +: JP4_W] = jp4_rxp;
		word_ext2[8 +: JP4_W]  = jp4_txn;
		word_ext2[0 +: JP4_W]  = jp4_txp;
	end

	// Registered read mux
	always_ff @(posedge axi_clk)
	begin
		case (acc.rd_idx)
			REG_FPGA_INFO: acc.rd_data <= fpga_rev;
			REG_HW_CTRL:   acc.rd_data <= word_hw;
			REG_EXT_CTRL1: acc.rd_data <= word_ext1;
			REG_EXT_CTRL2: acc.rd_data <= word_ext2;
			default:       acc.rd_data <= '0;
		endcase
	end

endmodule

`default_nettype wire

//--- axi_read_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module axi_read_ctrl (
	input  wire                         axi_clk,
	input  wire                         axi_rst,
	input  wire board_regs_pkg::axi_id_t   arid,
	input  wire board_regs_pkg::axi_addr_t araddr,
	input  wire board_regs_pkg::axi_len_t  arlen,
	input  wire                         arvalid,
	output logic                        arready,
	output board_regs_pkg::axi_id_t     rid,
	output board_regs_pkg::axi_data_t   rdata,
	output board_regs_pkg::axi_resp_t   rresp,
	output logic                        rlast,
	output logic                        rvalid,
	input  wire                         rready,
	reg_access_if.rd_side               acc
);
	import board_regs_pkg::*;

	logic     ar_hs;
	logic     r_hs;
	logic     ar_hs_d1;
	logic     ar_hs_d2;
	logic     rd_done;
	logic     advance;
	reg_idx_t next_idx;
	axi_len_t beat_cnt;

	assign ar_hs = arvalid & arready;
	assign r_hs  = rvalid & rready;

	// Output register loads on the first fetch and on every accepted beat
	assign advance = ar_hs_d2 | r_hs;

	// Look one word ahead when the output register takes the current word,
	// so rd_data already holds the next beat
	assign acc.rd_idx = advance ? next_idx + reg_idx_t'(1) : next_idx;

	assign rresp = RESP_OKAY;

	// ==========================================================
	// Handshake and burst control
	// ==========================================================
	always_ff @(posedge axi_clk)
	begin
		if (axi_rst)
		begin
			arready  <= 1'b1;
			ar_hs_d1 <= 1'b0;
			ar_hs_d2 <= 1'b0;
			rd_done  <= 1'b0;
			rvalid   <= 1'b0;
			rlast    <= 1'b0;
		end
		else
		begin
			// Index load, then register fetch, then output
			ar_hs_d1 <= ar_hs;
			ar_hs_d2 <= ar_hs_d1;
			rd_done  <= r_hs & rlast;
			arready  <= rd_done | (arready & ~ar_hs);
			rvalid   <= ar_hs_d2 | (rvalid & ~(r_hs & rlast));
			// Single-beat burst is last right away
			rlast    <= (ar_hs_d2 & (beat_cnt == '0))
				| (r_hs & (beat_cnt == axi_len_t'(1)))
				| (rlast & ~rready);
		end
	end

	// ==========================================================
	// Index, beat count, ID and data
	// ==========================================================
	always_ff @(posedge axi_clk)
	begin
		if (ar_hs)
		begin
			next_idx <= araddr[IDX_LSB +: IDX_W];
			beat_cnt <= arlen;
			rid      <= arid;
		end
		else
		begin
			if (advance)
			begin
				next_idx <= next_idx + reg_idx_t'(1);
			end
			if (r_hs)
			begin
				beat_cnt <= beat_cnt - axi_len_t'(1);
			end
		end

		if (advance)
		begin
			rdata <= acc.rd_data;
		end
	end

	assert property (@(posedge axi_clk) disable iff (axi_rst)
		rlast |-> rvalid)
	else
		$error("rlast raised without rvalid");

	// Beat stays on the bus unchanged through back-pressure
	assert property (@(posedge axi_clk) disable iff (axi_rst)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rid) && $stable(rlast))
	else
		$error("R beat changed or dropped before rready");

endmodule

`default_nettype wire

//--- axi_write_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module axi_write_ctrl (
	input  wire                         axi_clk,
	input  wire                         axi_rst,
	input  wire board_regs_pkg::axi_id_t   awid,
	input  wire board_regs_pkg::axi_addr_t awaddr,
	input  wire                         awvalid,
	output logic                        awready,
	input  wire board_regs_pkg::axi_data_t wdata,
	input  wire board_regs_pkg::axi_strb_t wstrb,
	input  wire                         wlast,
	input  wire                         wvalid,
	output logic                        wready,
	output board_regs_pkg::axi_id_t     bid,
	output board_regs_pkg::axi_resp_t   bresp,
	output logic                        bvalid,
	input  wire                         bready,
	reg_access_if.wr_side               acc
);
	import board_regs_pkg::*;

	logic     aw_hs;
	logic     w_hs;
	logic     b_hs;
	logic     wr_act;
	reg_idx_t beat_idx;

	assign aw_hs = awvalid & awready;
	assign w_hs  = wvalid & wready;
	assign b_hs  = bvalid & bready;

	// Address accepted only while idle
	assign awready = ~wr_act;
	assign bresp   = RESP_OKAY;

	// ==========================================================
	// Transaction state
	// ==========================================================
	always_ff @(posedge axi_clk)
	begin
		if (axi_rst)
		begin
			wr_act     <= 1'b0;
			wready     <= 1'b0;
			bvalid     <= 1'b0;
			acc.wr_en  <= 1'b0;
		end
		else
		begin
			// Busy from AW handshake until the response is taken
			wr_act    <= aw_hs | (wr_act & ~b_hs);
			wready    <= aw_hs | (wready & ~(w_hs & wlast));
			bvalid    <= (w_hs & wlast) | (bvalid & ~bready);
			acc.wr_en <= w_hs;
		end
	end

	// ==========================================================
	// Running index, response ID and beat payload
	// ==========================================================
	always_ff @(posedge axi_clk)
	begin
		if (aw_hs)
		begin
			beat_idx <= awaddr[IDX_LSB +: IDX_W];
			bid      <= awid;
		end
		else if (w_hs)
		begin
			beat_idx <= beat_idx + reg_idx_t'(1);
		end

		if (w_hs)
		begin
			acc.wr_idx  <= beat_idx;
			acc.wr_data <= wdata;
			acc.wr_strb <= wstrb;
		end
	end

	// Response must stay up, same ID, until the master takes it
	assert property (@(posedge axi_clk) disable iff (axi_rst)
		bvalid && !bready |=> bvalid && $stable(bid))
	else
		$error("bvalid dropped or bid changed before bready");

endmodule

`default_nettype wire

//--- reg_access_if.sv
`timescale 1ns/1ns
`default_nettype none

interface reg_access_if;
	import board_regs_pkg::*;

	// Write beat, one-cycle strobe on wr_en
	logic      wr_en;
	reg_idx_t  wr_idx;
	axi_data_t wr_data;
	axi_strb_t wr_strb;

	// Read lookup, rd_data follows rd_idx by one cycle
	reg_idx_t  rd_idx;
	axi_data_t rd_data;

	modport wr_side (
		output wr_en,
		output wr_idx,
		output wr_data,
		output wr_strb
	);

	modport rd_side (
		output rd_idx,
		input  rd_data
	);

	modport regs (
		input  wr_en,
		input  wr_idx,
		input  wr_data,
		input  wr_strb,
		input  rd_idx,
		output rd_data
	);

endinterface

`default_nettype wire

//--- board_regs_pkg.sv
`default_nettype none

package board_regs_pkg;

	// ==========================================================
	// AXI3 slave widths
	// ==========================================================
	localparam int ID_W    = 12;
	localparam int ADDR_W  = 30;
	localparam int DATA_W  = 32;
	localparam int STRB_W  = DATA_W / 8;
	localparam int LEN_W   = 4;
	localparam int RESP_W  = 2;

	// Word index comes from address bits 6..2
	localparam int IDX_LSB = 2;
	localparam int IDX_W   = 5;

	typedef logic [ID_W-1:0]   axi_id_t;
	typedef logic [ADDR_W-1:0] axi_addr_t;
	typedef logic [DATA_W-1:0] axi_data_t;
	typedef logic [STRB_W-1:0] axi_strb_t;
	typedef logic [LEN_W-1:0]  axi_len_t;
	typedef logic [RESP_W-1:0] axi_resp_t;
	typedef logic [IDX_W-1:0]  reg_idx_t;

	localparam axi_resp_t RESP_OKAY = 2'b00;

	// ==========================================================
	// Register map, as word indexes
	// ==========================================================
	localparam reg_idx_t REG_FPGA_INFO = 5'd0;
	localparam reg_idx_t REG_HW_CTRL   = 5'd1;
	localparam reg_idx_t REG_EXT_CTRL1 = 5'd2;
	localparam reg_idx_t REG_EXT_CTRL2 = 5'd3;

	// Board field widths
	localparam int SW1_W = 4;
	localparam int JP3_W = 4;
	localparam int LED_W = 3;
	localparam int JP5_W = 20;
	localparam int JP4_W = 6;

	// Output levels after reset
	localparam logic [JP3_W-1:0] JP3_RST = '0;
	localparam logic [LED_W-1:0] LED_RST = '1;
	localparam logic [JP5_W-1:0] JP5_RST = '1;
	localparam logic [JP4_W-1:0] JP4_RST = '1;

endpackage

`default_nettype wire
